/* vlog.f */
mem_pkg.sv
map_pkg.sv
credit_queue.sv
mem_arbiter.sv
word_store.sv
cart_loader.sv
rom_reader.sv
ram_port.sv
pce_mem_hub.sv
pce_mem_hub_chk.sv
tb_pce_mem_hub.sv

/* tb_pce_mem_hub.sv */
`timescale 1ns/1ps

module tb_pce_mem_hub;

	localparam int TIMEOUT_CYCLES = 500;

	logic        clk_sys;
	logic        reset;
	logic        load_active;
	logic        load_valid;
	logic [21:0] load_addr;
	logic [15:0] load_data;
	logic        load_wait;
	logic        rom_rd;
	logic [21:0] rom_addr;
	logic [7:0]  rom_q;
	logic        rom_ready;
	logic        wram_rd;
	logic        wram_wr;
	logic [15:0] wram_addr;
	logic [7:0]  wram_d;
	logic [7:0]  wram_q;
	logic        wram_ready;
	logic        aram_rd;
	logic        aram_wr;
	logic [15:0] aram_addr;
	logic [7:0]  aram_d;
	logic [7:0]  aram_q;
	logic        aram_ready;
	logic        rom_hdr;

	// Reference copies of the loaded image and both RAM regions
	logic [15:0] rom_img [4096];
	logic [7:0]  ram_model [2][65536];
	logic [31:0] lfsr = 32'h2eeb1ab2;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	pce_mem_hub #(.CREDITS(2), .STORE_WORDS(1 << 20)) UUT (
		.clk_sys(clk_sys), .reset(reset),
		.load_active(load_active), .load_valid(load_valid),
		.load_addr(load_addr), .load_data(load_data), .load_wait(load_wait),
		.rom_rd(rom_rd), .rom_addr(rom_addr), .rom_q(rom_q), .rom_ready(rom_ready),
		.wram_rd(wram_rd), .wram_wr(wram_wr), .wram_addr(wram_addr),
		.wram_d(wram_d), .wram_q(wram_q), .wram_ready(wram_ready),
		.aram_rd(aram_rd), .aram_wr(aram_wr), .aram_addr(aram_addr),
		.aram_d(aram_d), .aram_q(aram_q), .aram_ready(aram_ready),
		.rom_hdr(rom_hdr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ==============================
	// Helpers

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// Testbench errors plus failed assertions in the bound checker
	function automatic int error_count();
		return errors + UUT.u_chk.fail_count;
	endfunction

	// Odd byte addresses live in the high half of the word
	function automatic logic [7:0] image_byte(input int b);
		return b[0] ? rom_img[b / 2][15:8] : rom_img[b / 2][7:0];
	endfunction

	function automatic logic port_ready(input bit aram);
		return aram ? aram_ready : wram_ready;
	endfunction

	task automatic compare_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s expected %02h, got %02h", $time, name,
				expected, actual);
			errors++;
		end
	endtask

	task automatic load_image(input int words);
		int n;
		for (int w = 0; w < words; w++) begin
			rom_img[w] = 16'(next_bits(16));
		end
		@(posedge clk_sys);
		load_active <= 1'b1;
		for (int w = 0; w < words; w++) begin
			load_valid <= 1'b1;
			load_addr <= 22'(2 * w);
			load_data <= rom_img[w];
			@(negedge clk_sys);
			n = 0;
			while (load_wait && n < TIMEOUT_CYCLES) begin
				@(negedge clk_sys);
				n++;
			end
			if (load_wait) begin
				$display("Timeout at %0t: load_wait stayed high at word %0d", $time, w);
				errors++;
				@(posedge clk_sys);
				break;
			end
			@(posedge clk_sys);
		end
		load_valid <= 1'b0;
		load_active <= 1'b0;
	endtask

	task automatic read_rom_byte(input logic [21:0] addr, output logic [7:0] q);
		int n;
		q = 'x;
		n = 0;
		@(negedge clk_sys);
		while (!rom_ready && n < TIMEOUT_CYCLES) begin
			@(negedge clk_sys);
			n++;
		end
		if (!rom_ready) begin
			$display("Timeout at %0t: rom_ready stayed low before a read", $time);
			errors++;
			return;
		end
		@(posedge clk_sys);
		rom_rd <= 1'b1;
		rom_addr <= addr;
		@(posedge clk_sys);
		rom_rd <= 1'b0;
		@(negedge clk_sys);
		n = 0;
		while (!rom_ready && n < TIMEOUT_CYCLES) begin
			@(negedge clk_sys);
			n++;
		end
		if (!rom_ready) begin
			$display("Timeout at %0t: ROM read of %h never completed", $time, addr);
			errors++;
			return;
		end
		q = rom_q;
	endtask

	task automatic verify_rom_byte(input int addr, input int offset);
		logic [7:0] q;
		read_rom_byte(22'(addr), q);
		compare_byte("rom_q", image_byte(addr + offset), q);
	endtask

	task automatic access_ram(input bit aram, input bit write, input logic [15:0] addr,
		input logic [7:0] d, output logic [7:0] q);
		int n;
		q = 'x;
		n = 0;
		@(negedge clk_sys);
		while (!port_ready(aram) && n < TIMEOUT_CYCLES) begin
			@(negedge clk_sys);
			n++;
		end
		if (!port_ready(aram)) begin
			$display("Timeout at %0t: RAM port %0d stayed busy before access", $time, aram);
			errors++;
			return;
		end
		@(posedge clk_sys);
		if (aram) begin
			aram_rd <= !write;
			aram_wr <= write;
			aram_addr <= addr;
			aram_d <= d;
		end else begin
			wram_rd <= !write;
			wram_wr <= write;
			wram_addr <= addr;
			wram_d <= d;
		end
		@(posedge clk_sys);
		if (aram) begin
			aram_rd <= 1'b0;
			aram_wr <= 1'b0;
		end else begin
			wram_rd <= 1'b0;
			wram_wr <= 1'b0;
		end
		@(negedge clk_sys);
		n = 0;
		while (!port_ready(aram) && n < TIMEOUT_CYCLES) begin
			@(negedge clk_sys);
			n++;
		end
		if (!port_ready(aram)) begin
			$display("Timeout at %0t: RAM port %0d access never completed", $time, aram);
			errors++;
			return;
		end
		q = aram ? aram_q : wram_q;
		if (write) begin
			ram_model[aram][addr] = d;
		end
	endtask

	task automatic verify_ram_byte(input bit aram, input logic [15:0] addr);
		logic [7:0] q;
		access_ram(aram, 1'b0, addr, 8'h00, q);
		compare_byte(aram ? "aram_q" : "wram_q", ram_model[aram][addr], q);
	endtask

	task automatic ram_traffic(input bit aram, input int count);
		logic [15:0] addrs [$];
		logic [15:0] a;
		logic [7:0]  q;
		int          pick;
		for (int i = 0; i < count; i++) begin
			a = 16'(next_bits(16));
			access_ram(aram, 1'b1, a, 8'(next_bits(8)), q);
			addrs.push_back(a);
			pick = int'(next_bits(16) % addrs.size());
			verify_ram_byte(aram, addrs[pick]);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (error_count() == errs_before) begin
			$display("%s: PASS", name);
		end else begin
			tests_failed++;
			$display("%s: FAIL (%0d errors)", name, error_count() - errs_before);
		end
	endtask

	// ==============================
	// Directed tests

	// Header rule comes from the image size in bytes modulo 1024
	task automatic image_reads(input string name, input int words, input int reads);
		int   errs;
		int   offset;
		int   a;
		logic hdr_exp;
		errs = error_count();
		hdr_exp = ((words * 2) % 1024) == 512;
		offset = hdr_exp ? 512 : 0;
		load_image(words);
		for (int i = 0; i < reads; i++) begin
			a = (i < 2) ? i : int'(next_bits(12));
			verify_rom_byte(a, offset);
		end
		if (rom_hdr !== hdr_exp) begin
			$display("Mismatch at %0t: rom_hdr expected %b, got %b", $time, hdr_exp, rom_hdr);
			errors++;
		end
		finish_test(name, errs);
	endtask

	task automatic byte_write_merge();
		int          errs;
		logic [15:0] a;
		logic [7:0]  q;
		errs = error_count();
		a = {15'(next_bits(15)), 1'b0};
		access_ram(1'b0, 1'b1, a, 8'(next_bits(8)), q);
		access_ram(1'b0, 1'b1, a + 16'd1, 8'(next_bits(8)), q);
		// Overwrite only the low byte of the word
		access_ram(1'b0, 1'b1, a, 8'(next_bits(8)), q);
		verify_ram_byte(1'b0, a);
		verify_ram_byte(1'b0, a + 16'd1);
		finish_test("wram byte write", errs);
	endtask

	task automatic region_separation();
		int          errs;
		logic [15:0] offs [8];
		logic [7:0]  d;
		logic [7:0]  q;
		errs = error_count();
		for (int i = 0; i < 8; i++) begin
			offs[i] = 16'(next_bits(16));
			d = 8'(next_bits(8));
			access_ram(1'b0, 1'b1, offs[i], d, q);
			access_ram(1'b1, 1'b1, offs[i], ~d, q);
		end
		for (int i = 0; i < 8; i++) begin
			verify_ram_byte(1'b0, offs[i]);
			verify_ram_byte(1'b1, offs[i]);
		end
		finish_test("wram and aram regions", errs);
	endtask

	task automatic load_with_ram_traffic();
		int errs;
		errs = error_count();
		fork
			load_image(512);
			ram_traffic(1'b0, 48);
			ram_traffic(1'b1, 48);
		join
		for (int a = 0; a < 1024; a++) begin
			verify_rom_byte(a, 0);
		end
		finish_test("load with RAM traffic", errs);
	endtask

	initial begin
		reset = 1'b1;
		load_active = 1'b0;
		load_valid = 1'b0;
		load_addr = '0;
		load_data = '0;
		rom_rd = 1'b0;
		rom_addr = '0;
		wram_rd = 1'b0;
		wram_wr = 1'b0;
		wram_addr = '0;
		wram_d = '0;
		aram_rd = 1'b0;
		aram_wr = 1'b0;
		aram_addr = '0;
		aram_d = '0;
		repeat (2) @(posedge clk_sys);

		// First load starts on the edge that releases reset
		fork
			begin
				@(posedge clk_sys);
				reset <= 1'b0;
			end
			image_reads("4 KB image", 2048, 32);
		join
		image_reads("4 KB image with header", 2304, 32);
		byte_write_merge();
		region_separation();
		load_with_ram_traffic();

		$display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run,
			tests_failed, error_count());
		if (error_count() == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* pce_mem_hub_chk.sv */
`timescale 1ns/1ps

module pce_mem_hub_chk #(
	parameter int CREDITS = 2
) (
	input logic                                clk_sys,
	input logic                                reset,
	input logic                                load_wait,
	input logic [3:0]                          push,
	input logic [3:0][$clog2(CREDITS + 1)-1:0] credits,
	input logic [3:0][$clog2(CREDITS + 1)-1:0] queue_count
);

	int fail_count = 0;

	// ==============================
	// Per-client credit rules
	for (genvar i = 0; i < 4; i++) begin : g_client
		// A push is only legal while the queue still has a free slot
		a_push_has_credit: assert property (
			@(posedge clk_sys) disable iff (reset) push[i] |-> queue_count[i] != CREDITS
		) else begin
			$error("Client %0d pushed into a full queue", i);
			fail_count++;
		end

		a_credit_bound: assert property (
			@(posedge clk_sys) disable iff (reset) credits[i] <= CREDITS
		) else begin
			$error("Client %0d holds more than %0d credits", i, CREDITS);
			fail_count++;
		end
	end

	// Loader accepts right away once out of reset
	a_wait_after_reset: assert property (
		@(posedge clk_sys) $fell(reset) |-> !load_wait
	) else begin
		$error("load_wait high in the cycle after reset");
		fail_count++;
	end

endmodule

bind pce_mem_hub pce_mem_hub_chk #(.CREDITS(CREDITS)) u_chk (
	.clk_sys(clk_sys), .reset(reset), .load_wait(load_wait), .push(push),
	.credits({u_aram.credits, u_wram.credits, u_rom.credits, u_loader.credits}),
	.queue_count({g_queue[3].u_queue.count, g_queue[2].u_queue.count,
		g_queue[1].u_queue.count, g_queue[0].u_queue.count})
);

/* pce_mem_hub.sv */
`timescale 1ns/1ps

module pce_mem_hub #(
	parameter int CREDITS     = 2,
	parameter int STORE_WORDS = 1 << 20
) (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  logic                                    load_active,
	input  logic                                    load_valid,
	input  logic [map_pkg::ROM_ADDR_BITS-1:0]       load_addr,
	input  mem_pkg::word_t                          load_data,
	output logic                                    load_wait,
	input  logic                                    rom_rd,
	input  logic [map_pkg::ROM_ADDR_BITS-1:0]       rom_addr,
	output mem_pkg::byte_t                          rom_q,
	output logic                                    rom_ready,
	input  logic                                    wram_rd,
	input  logic                                    wram_wr,
	input  logic [$clog2(map_pkg::WRAM_WORDS):0]    wram_addr,
	input  mem_pkg::byte_t                          wram_d,
	output mem_pkg::byte_t                          wram_q,
	output logic                                    wram_ready,
	input  logic                                    aram_rd,
	input  logic                                    aram_wr,
	input  logic [$clog2(map_pkg::ARAM_WORDS):0]    aram_addr,
	input  mem_pkg::byte_t                          aram_d,
	output mem_pkg::byte_t                          aram_q,
	output logic                                    aram_ready,
	output logic                                    rom_hdr
);

	localparam int N = mem_pkg::NUM_CLIENTS;

	logic [N-1:0]         push;
	logic [N-1:0]         pop;
	logic [N-1:0]         not_empty;
	logic [N-1:0]         credit_return;
	logic [N-1:0]         rsp_valid;
	mem_pkg::mem_req_t    reqs [N];
	mem_pkg::mem_req_t    heads [N];
	mem_pkg::word_t       rsp_data;
	logic                 store_req_valid;
	mem_pkg::tagged_req_t store_req;
	logic                 store_rsp_valid;
	mem_pkg::mem_rsp_t    store_rsp;

	// ==============================
	// Clients

	cart_loader #(.CREDITS(CREDITS)) u_loader (
		.clk_sys(clk_sys), .reset(reset),
		.load_active(load_active), .load_valid(load_valid),
		.load_addr(load_addr), .load_data(load_data), .load_wait(load_wait),
		.req_push(push[mem_pkg::CL_LOADER]), .req(reqs[mem_pkg::CL_LOADER]),
		.credit_return(credit_return[mem_pkg::CL_LOADER]), .rom_hdr(rom_hdr)
	);

	rom_reader #(.CREDITS(CREDITS)) u_rom (
		.clk_sys(clk_sys), .reset(reset), .load_active(load_active), .rom_hdr(rom_hdr),
		.rom_rd(rom_rd), .rom_addr(rom_addr), .rom_q(rom_q), .rom_ready(rom_ready),
		.req_push(push[mem_pkg::CL_ROM]), .req(reqs[mem_pkg::CL_ROM]),
		.credit_return(credit_return[mem_pkg::CL_ROM]),
		.rsp_valid(rsp_valid[mem_pkg::CL_ROM]), .rsp_data(rsp_data)
	);

	ram_port #(
		.BASE(map_pkg::WRAM_BASE), .WORDS(map_pkg::WRAM_WORDS), .CREDITS(CREDITS)
	) u_wram (
		.clk_sys(clk_sys), .reset(reset), .rd(wram_rd), .wr(wram_wr),
		.addr(wram_addr), .d(wram_d), .q(wram_q), .ready(wram_ready),
		.req_push(push[mem_pkg::CL_WRAM]), .req(reqs[mem_pkg::CL_WRAM]),
		.credit_return(credit_return[mem_pkg::CL_WRAM]),
		.rsp_valid(rsp_valid[mem_pkg::CL_WRAM]), .rsp_data(rsp_data)
	);

	ram_port #(
		.BASE(map_pkg::ARAM_BASE), .WORDS(map_pkg::ARAM_WORDS), .CREDITS(CREDITS)
	) u_aram (
		.clk_sys(clk_sys), .reset(reset), .rd(aram_rd), .wr(aram_wr),
		.addr(aram_addr), .d(aram_d), .q(aram_q), .ready(aram_ready),
		.req_push(push[mem_pkg::CL_ARAM]), .req(reqs[mem_pkg::CL_ARAM]),
		.credit_return(credit_return[mem_pkg::CL_ARAM]),
		.rsp_valid(rsp_valid[mem_pkg::CL_ARAM]), .rsp_data(rsp_data)
	);

	// ==============================
	// One request queue per client

	for (genvar i = 0; i < N; i++) begin : g_queue
		credit_queue #(.payload_t(mem_pkg::mem_req_t), .DEPTH(CREDITS)) u_queue (
			.clk_sys(clk_sys), .reset(reset),
			.push(push[i]), .din(reqs[i]),
			.pop(pop[i]), .dout(heads[i]),
			.not_empty(not_empty[i]), .credit_return(credit_return[i])
		);
	end

	// ==============================
	// Arbiter and store

	mem_arbiter #(.N(N)) u_arbiter (
		.clk_sys(clk_sys), .reset(reset),
		.not_empty(not_empty), .heads(heads), .pop(pop),
		.store_req_valid(store_req_valid), .store_req(store_req),
		.store_rsp_valid(store_rsp_valid), .store_rsp(store_rsp),
		.rsp_valid(rsp_valid), .rsp_data(rsp_data)
	);

	word_store #(.STORE_WORDS(STORE_WORDS)) u_store (
		.clk_sys(clk_sys),
		.store_req_valid(store_req_valid), .store_req(store_req),
		.store_rsp_valid(store_rsp_valid), .store_rsp(store_rsp)
	);

endmodule

/* ram_port.sv */
`timescale 1ns/1ps

module ram_port #(
	parameter int unsigned BASE    = 0,
	parameter int unsigned WORDS   = 1 << 15,
	parameter int          CREDITS = 2
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   rd,
	input  logic                   wr,
	input  logic [$clog2(WORDS):0] addr,
	input  mem_pkg::byte_t         d,
	output mem_pkg::byte_t         q,
	output logic                   ready,
	output logic                   req_push,
	output mem_pkg::mem_req_t      req,
	input  logic                   credit_return,
	input  logic                   rsp_valid,
	input  mem_pkg::word_t         rsp_data
);

	localparam int AW = $clog2(WORDS);
	localparam int CW = $clog2(CREDITS + 1);

	logic [CW-1:0]  credits;
	logic           busy;
	logic           pend;
	logic           byte_sel;
	logic           strobe;
	mem_pkg::word_t word_q;

	assign ready = !busy;
	assign strobe = (rd || wr) && ready;
	assign req_push = pend && (credits != '0);
	assign q = byte_sel ? word_q[15:8] : word_q[7:0];

	// ==============================
	// Control

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			credits <= CW'(CREDITS);
			busy <= 1'b0;
			pend <= 1'b0;
		end else begin
			credits <= credits + CW'(credit_return) - CW'(req_push);
			if (req_push) begin
				pend <= 1'b0;
				// Write is done for the port once it is queued
				if (req.write) begin
					busy <= 1'b0;
				end
			end
			if (rsp_valid) begin
				busy <= 1'b0;
			end
			if (strobe) begin
				busy <= 1'b1;
				pend <= 1'b1;
			end
		end
	end

	// ==============================
	// Request and read data

	// Byte goes to both lanes, enable picks the addressed one
	always_ff @(posedge clk_sys) begin
		if (strobe) begin
			byte_sel <= addr[0];
			req.waddr <= mem_pkg::waddr_t'(BASE + 32'(addr[AW:1]));
			req.data <= {d, d};
			req.be <= wr ? {addr[0], !addr[0]} : 2'b11;
			req.write <= wr;
		end
		if (rsp_valid) begin
			word_q <= rsp_data;
		end
	end

endmodule

/* rom_reader.sv */
`timescale 1ns/1ps

module rom_reader #(
	parameter int CREDITS = 2
) (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              load_active,
	input  logic                              rom_hdr,
	input  logic                              rom_rd,
	input  logic [map_pkg::ROM_ADDR_BITS-1:0] rom_addr,
	output mem_pkg::byte_t                    rom_q,
	output logic                              rom_ready,
	output logic                              req_push,
	output mem_pkg::mem_req_t                 req,
	input  logic                              credit_return,
	input  logic                              rsp_valid,
	input  mem_pkg::word_t                    rsp_data
);

	localparam int CW = $clog2(CREDITS + 1);

	logic [CW-1:0]   credits;
	logic            busy;
	logic            pend;
	logic            word_valid;
	logic            byte_sel;
	logic            strobe;
	logic            hit;
	logic [31:0]     rom_word;
	mem_pkg::waddr_t fetch_waddr;
	mem_pkg::word_t  word_q;

	assign rom_ready = !busy && !load_active;
	assign strobe = rom_rd && rom_ready;
	assign req_push = pend && (credits != '0);

	// Header images start 256 words further in
	assign rom_word = 32'(rom_addr[map_pkg::ROM_ADDR_BITS-1:1])
		+ (rom_hdr ? map_pkg::HDR_BYTES / 2 : 32'd0);
	assign fetch_waddr = mem_pkg::waddr_t'(map_pkg::rom_word_addr(rom_word));

	// Last request doubles as the tag of the held word
	assign hit = word_valid && (req.waddr == fetch_waddr);
	assign rom_q = byte_sel ? word_q[15:8] : word_q[7:0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			credits <= CW'(CREDITS);
			busy <= 1'b0;
			pend <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			credits <= credits + CW'(credit_return) - CW'(req_push);
			if (req_push) begin
				pend <= 1'b0;
			end
			if (rsp_valid) begin
				busy <= 1'b0;
				word_valid <= 1'b1;
			end
			if (strobe && !hit) begin
				busy <= 1'b1;
				pend <= 1'b1;
			end
			// New image contents, held word is stale
			if (load_active) begin
				word_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (strobe) begin
			byte_sel <= rom_addr[0];
		end
		if (strobe && !hit) begin
			req.waddr <= fetch_waddr;
			req.data <= '0;
			req.be <= 2'b11;
			req.write <= 1'b0;
		end
		if (rsp_valid) begin
			word_q <= rsp_data;
		end
	end

endmodule

/* cart_loader.sv */
`timescale 1ns/1ps

module cart_loader #(
	parameter int CREDITS = 2
) (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              load_active,
	input  logic                              load_valid,
	input  logic [map_pkg::ROM_ADDR_BITS-1:0] load_addr,
	input  mem_pkg::word_t                    load_data,
	output logic                              load_wait,
	output logic                              req_push,
	output mem_pkg::mem_req_t                 req,
	input  logic                              credit_return,
	output logic                              rom_hdr
);

	localparam int CW = $clog2(CREDITS + 1);

	logic [CW-1:0]                     credits;
	logic                              load_active_d;
	logic                              load_start;
	logic                              load_end;
	logic [map_pkg::ROM_ADDR_BITS-1:0] max_addr;
	logic [31:0]                       load_word;
	logic [31:0]                       image_mod;

	assign load_start = load_active && !load_active_d;
	assign load_end = !load_active && load_active_d;

	// A word moves in any cycle with a credit left
	assign req_push = load_active && load_valid && (credits != '0);
	assign load_wait = load_active && load_valid && (credits == '0);

	assign load_word = 32'(load_addr[map_pkg::ROM_ADDR_BITS-1:1]);
	always_comb begin
		req.waddr = mem_pkg::waddr_t'(map_pkg::rom_word_addr(load_word));
		req.data = load_data;
		req.be = 2'b11;
		req.write = 1'b1;
	end

	// Image size is highest word address plus two bytes
	assign image_mod = (32'(max_addr) + 32'd2) % map_pkg::HDR_MOD;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			credits <= CW'(CREDITS);
			load_active_d <= 1'b0;
			rom_hdr <= 1'b0;
		end else begin
			credits <= credits + CW'(credit_return) - CW'(req_push);
			load_active_d <= load_active;
			if (load_start) begin
				rom_hdr <= 1'b0;
			end else if (load_end) begin
				rom_hdr <= (image_mod == map_pkg::HDR_BYTES);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (load_start) begin
			max_addr <= '0;
		end
		if (req_push && (load_start || load_addr > max_addr)) begin
			max_addr <= load_addr;
		end
	end

endmodule

/* word_store.sv */
`timescale 1ns/1ps

module word_store #(
	parameter int STORE_WORDS = 1 << 20
) (
	input  logic                 clk_sys,
	input  logic                 store_req_valid,
	input  mem_pkg::tagged_req_t store_req,
	output logic                 store_rsp_valid,
	output mem_pkg::mem_rsp_t    store_rsp
);

	localparam int AW = $clog2(STORE_WORDS);
	localparam int LAT = mem_pkg::READ_LATENCY;

	mem_pkg::word_t    mem [STORE_WORDS];
	logic [AW-1:0]     idx;
	logic              rd_accept;
	logic [LAT-1:0]    pipe_valid;
	mem_pkg::mem_rsp_t pipe [LAT];

	assign idx = store_req.req.waddr[AW-1:0];
	assign rd_accept = store_req_valid && !store_req.req.write;

	// Writes land in the accept cycle, lane by lane
	always_ff @(posedge clk_sys) begin
		if (store_req_valid && store_req.req.write) begin
			if (store_req.req.be[0]) begin
				mem[idx][7:0] <= store_req.req.data[7:0];
			end
			if (store_req.req.be[1]) begin
				mem[idx][15:8] <= store_req.req.data[15:8];
			end
		end
	end

	// Read pipeline carries the client tag alongside the word
	always_ff @(posedge clk_sys) begin
		pipe_valid[0] <= rd_accept;
		pipe[0].client <= store_req.client;
		pipe[0].data <= mem[idx];
		for (int i = 1; i < LAT; i++) begin
			pipe_valid[i] <= pipe_valid[i-1];
			pipe[i] <= pipe[i-1];
		end
	end

	assign store_rsp_valid = pipe_valid[LAT-1];
	assign store_rsp = pipe[LAT-1];

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter #(
	parameter int N = 4
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic [N-1:0]         not_empty,
	input  mem_pkg::mem_req_t    heads [N],
	output logic [N-1:0]         pop,
	output logic                 store_req_valid,
	output mem_pkg::tagged_req_t store_req,
	input  logic                 store_rsp_valid,
	input  mem_pkg::mem_rsp_t    store_rsp,
	output logic [N-1:0]         rsp_valid,
	output mem_pkg::word_t       rsp_data
);

	localparam int PW = (N > 1) ? $clog2(N) : 1;

	logic [PW-1:0] last;
	logic [PW-1:0] grant;
	logic          found;

	// ==============================
	// Request side

	// Search begins one past the last granted client
	always_comb begin
		int idx;
		found = 1'b0;
		grant = last;
		for (int k = 1; k <= N; k++) begin
			idx = (int'(last) + k) % N;
			if (!found && not_empty[idx]) begin
				found = 1'b1;
				grant = PW'(idx);
			end
		end
	end

	always_comb begin
		pop = '0;
		if (found) begin
			pop[grant] = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			store_req_valid <= 1'b0;
			last <= PW'(N - 1);
		end else begin
			store_req_valid <= found;
			if (found) begin
				last <= grant;
			end
		end
	end

	// Head entry goes out tagged with its queue index
	always_ff @(posedge clk_sys) begin
		store_req.client <= mem_pkg::client_t'(grant);
		store_req.req <= heads[grant];
	end

	// ==============================
	// Response side

	always_comb begin
		for (int i = 0; i < N; i++) begin
			rsp_valid[i] = store_rsp_valid && (int'(store_rsp.client) == i);
		end
	end

	// Data is shared, only the owner sees a valid
	assign rsp_data = store_rsp.data;

endmodule

/* credit_queue.sv */
`timescale 1ns/1ps

module credit_queue #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 2
) (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     push,
	input  payload_t din,
	input  logic     pop,
	output payload_t dout,
	output logic     not_empty,
	output logic     credit_return
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t      slots [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	function automatic logic [PW-1:0] next_ptr(logic [PW-1:0] ptr);
		return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push = push && (count != CW'(DEPTH));
	assign do_pop = pop && not_empty;
	assign not_empty = (count != '0);
	assign dout = slots[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			slots[wr_ptr] <= din;
		end
	end

	// One credit back for every entry that leaves
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= do_pop;
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CW'(do_push) - CW'(do_pop);
		end
	end

endmodule

/* map_pkg.sv */
package map_pkg;

	// ==============================
	// Word regions in the store
	localparam int unsigned ROM_BASE   = 32'h0000_0000;
	localparam int unsigned ROM_WORDS  = 1 << 19;
	localparam int unsigned WRAM_BASE  = 32'h0008_0000;
	localparam int unsigned WRAM_WORDS = 1 << 15;
	localparam int unsigned ARAM_BASE  = 32'h0008_8000;
	localparam int unsigned ARAM_WORDS = 1 << 15;

	// Byte address width on the ROM side, load stream and CPU port
	localparam int ROM_ADDR_BITS = 22;

	// ==============================
	// Copier header, seen as image size modulo 1024
	localparam int unsigned HDR_BYTES = 512;
	localparam int unsigned HDR_MOD   = 1024;

	// Store address of a ROM word, wraps inside the region
	function automatic int unsigned rom_word_addr(int unsigned rom_word);
		return ROM_BASE + (rom_word % ROM_WORDS);
	endfunction

endpackage

/* mem_pkg.sv */
package mem_pkg;

	// Memory word and byte
	typedef logic [15:0] word_t;
	typedef logic [7:0] byte_t;

	// Word address into the store
	typedef logic [19:0] waddr_t;

	// Client ids, in round-robin order
	typedef enum logic [1:0] {
		CL_LOADER = 2'd0,
		CL_ROM    = 2'd1,
		CL_WRAM   = 2'd2,
		CL_ARAM   = 2'd3
	} client_t;

	localparam int NUM_CLIENTS = 4;

	// be[1] enables the high byte, be[0] the low byte
	typedef struct packed {
		waddr_t     waddr;
		word_t      data;
		logic [1:0] be;
		logic       write;
	} mem_req_t;

	// Request on its way from the arbiter to the store
	typedef struct packed {
		client_t  client;
		mem_req_t req;
	} tagged_req_t;

	typedef struct packed {
		client_t client;
		word_t   data;
	} mem_rsp_t;

	// Cycles from store acceptance to response
	localparam int READ_LATENCY = 2;

endpackage
